// File: Bender.yml
package:
  name: oram_frontend

sources:
  - logic/oramPkg.sv
  - logic/posMapCache.sv
  - logic/recursionCtrl.sv
  - logic/dataScheduler.sv
  - logic/oramFrontend.sv
  - target: simulation
    files:
      - dv/backendModel.sv
      - dv/oramFrontendTb.sv

// File: dv/backendModel.sv
`timescale 1ns/1ns

module backendModel (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         CmdInValid,
    input  logic                         CmdInReady,
    input  oramPkg::feCmdT               CmdIn,
    input  logic                         CmdOutValid,
    input  logic                         CmdOutReady,
    input  oramPkg::beCmdT               CmdOut,
    output logic                         LoadValid,
    output logic [oramPkg::FEDWidth-1:0] LoadData,
    output int                           faultCount
);

    // block store, one slot per address
    logic                         present [2**oramPkg::ORAMU];
    logic [oramPkg::ORAML-1:0]    leafOf  [2**oramPkg::ORAMU];
    logic [oramPkg::FEDWidth-1:0] dataOf  [2**oramPkg::ORAMU];
    logic [oramPkg::FEDWidth-1:0] loadQ   [$];
    logic [oramPkg::ORAMU-1:0]    progAddr;

    // first level-1 block plus address over leaves per block
    function automatic logic [oramPkg::ORAMU-1:0] parentBlock(input logic [oramPkg::ORAMU-1:0] a);
        return oramPkg::NumValidBlock + a / oramPkg::LeafInBlock;
    endfunction

    task automatic logFault(input string msg);
        $display("error %0t: %s", $time, msg);
        faultCount++;
    endtask

    // ==================================================================
    // command side sampled mid-cycle
    // ==================================================================
    always @(negedge Clock) begin : watchCmd
        oramPkg::beCmdT c;
        logic           isAccess;
        c        = CmdOut;
        isAccess = c.op != oramPkg::BeAppend;
        if (rstN && CmdInValid && CmdInReady) begin
            progAddr = CmdIn.addr;
        end
        if (rstN && CmdOutValid && CmdOutReady) begin
            assert (c.newLeaf != '0) else logFault($sformatf("zero new leaf for block %0d", c.addr));
            assert (c.addr < oramPkg::Level2Base + oramPkg::RootEntries)
                else logFault($sformatf("block %0d is outside the position map", c.addr));
            if (isAccess) begin
                assert (present[c.addr])
                    else logFault($sformatf("block %0d is absent, an append was due", c.addr));
                if (present[c.addr]) begin
                    assert (leafOf[c.addr] == c.oldLeaf)
                        else logFault($sformatf("block %0d old leaf %0d, stored leaf %0d",
                                                c.addr, c.oldLeaf, leafOf[c.addr]));
                end
            end else begin
                assert (!present[c.addr])
                    else logFault($sformatf("append to block %0d that is still stored", c.addr));
            end
            // fetches only along the path of the program address
            if (c.op == oramPkg::BeReadRmv) begin
                assert (c.addr == parentBlock(progAddr) ||
                        c.addr == parentBlock(parentBlock(progAddr)))
                    else logFault($sformatf("fetch of block %0d while serving address %0d",
                                            c.addr, progAddr));
            end
            if (c.addr < oramPkg::NumValidBlock) begin
                assert (c.addr == progAddr)
                    else logFault($sformatf("data block %0d while serving address %0d",
                                            c.addr, progAddr));
            end
            case (c.op)
                oramPkg::BeRead: begin
                    leafOf[c.addr] = c.newLeaf;
                    loadQ.push_back(dataOf[c.addr]);
                end
                oramPkg::BeReadRmv: begin
                    present[c.addr] = 1'b0;
                    loadQ.push_back(dataOf[c.addr]);
                end
                default: begin
                    present[c.addr] = 1'b1;
                    leafOf[c.addr]  = c.newLeaf;
                    dataOf[c.addr]  = c.data;
                end
            endcase
        end
    end

    // loads come back in order one cycle after the transfer
    initial begin
        LoadValid  = 1'b0;
        LoadData   = '0;
        faultCount = 0;
        for (int a = 0; a < 2**oramPkg::ORAMU; a++) begin
            present[a] = 1'b0;
        end
        forever begin
            @(posedge Clock);
            #2;
            if (loadQ.size() != 0) begin
                LoadValid = 1'b1;
                LoadData  = loadQ.pop_front();
            end else begin
                LoadValid = 1'b0;
            end
        end
    end

endmodule

// File: dv/oramFrontendTb.sv
`timescale 1ns/1ns

module oramFrontendTb;

    logic                         Clock;
    logic                         rstN;
    logic                         CmdInValid;
    logic                         CmdInReady;
    oramPkg::feCmdT               CmdIn;
    logic                         ReturnValid;
    logic                         ReturnReady;
    logic [oramPkg::FEDWidth-1:0] ReturnData;
    logic                         CmdOutValid;
    logic                         CmdOutReady;
    oramPkg::beCmdT               CmdOut;
    logic                         LoadValid;
    logic [oramPkg::FEDWidth-1:0] LoadData;

    int  seed = 25832;
    int  modelFaults;
    int  dataErrors = 0;
    int  protocolErrors = 0;
    bit  timedOut = 1'b0;

    // expected memory contents and expected read words in order
    logic [oramPkg::FEDWidth-1:0] shadow [oramPkg::NumValidBlock];
    logic [oramPkg::FEDWidth-1:0] expQ   [$];
    oramPkg::beCmdT               heldCmd;
    logic                         holdPending = 1'b0;
    logic                         nextOutReady;
    logic                         nextRetReady;

    oramFrontend i_dut (.*);

    backendModel i_backend (.*, .faultCount(modelFaults));

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    // random back-pressure on both ready inputs
    initial begin
        CmdOutReady = 1'b0;
        ReturnReady = 1'b0;
        forever begin
            @(negedge Clock);
            nextOutReady = ($unsigned($random(seed)) % 100) >= 30;
            nextRetReady = ($unsigned($random(seed)) % 100) >= 25;
            @(posedge Clock);
            #2;
            CmdOutReady = nextOutReady;
            ReturnReady = nextRetReady;
        end
    end

    // ==================================================================
    // output checks
    // ==================================================================
    always @(negedge Clock) begin : watchOutputs
        logic [oramPkg::FEDWidth-1:0] expected;
        if (rstN) begin
            if (holdPending) begin
                assert (CmdOutValid && CmdOut == heldCmd) else begin
                    $display("error %0t: backend command changed before it was taken", $time);
                    protocolErrors++;
                end
            end
            holdPending = CmdOutValid && !CmdOutReady;
            heldCmd     = CmdOut;
            if (ReturnValid && ReturnReady) begin
                assert (expQ.size() != 0) else begin
                    $display("a return word came back with no read outstanding");
                    protocolErrors++;
                end
                if (expQ.size() != 0) begin
                    expected = expQ.pop_front();
                    assert (ReturnData == expected) else begin
                        $display("error %0t: read returned %h, expected %h",
                                 $time, ReturnData, expected);
                        dataErrors++;
                    end
                end
            end
        end
    end

    task automatic sendCmd(input oramPkg::feOpE op, input logic [oramPkg::ORAMU-1:0] addr,
                           input logic [oramPkg::FEDWidth-1:0] data, input int index);
        int waited;
        waited     = 0;
        CmdIn.op   = op;
        CmdIn.addr = addr;
        CmdIn.data = data;
        CmdInValid = 1'b1;
        if (op == oramPkg::FeRead) begin
            expQ.push_back(shadow[addr]);
        end else begin
            shadow[addr] = data;
        end
        do begin
            @(negedge Clock);
            waited++;
        end while (!CmdInReady && waited < 2000);
        if (!CmdInReady) begin
            $display("timeout: command %0d was not accepted within 2000 cycles", index);
            timedOut = 1'b1;
        end
        @(posedge Clock);
        #2;
        CmdInValid = 1'b0;
    endtask

    // ==================================================================
    // stimulus
    // ==================================================================
    initial begin : stimulus
        int                           waited;
        int                           addr;
        oramPkg::feOpE                op;
        logic [oramPkg::FEDWidth-1:0] data;
        rstN       = 1'b0;
        CmdInValid = 1'b0;
        CmdIn      = '0;
        for (int a = 0; a < oramPkg::NumValidBlock; a++) begin
            shadow[a] = '0;
        end
        repeat (2) @(posedge Clock);
        #2;
        rstN = 1'b1;
        @(negedge Clock);
        assert (!CmdOutValid && !ReturnValid && CmdInReady) else begin
            $display("error %0t: outputs not idle after reset", $time);
            protocolErrors++;
        end
        @(posedge Clock);
        #2;
        for (int i = 0; i < 300 && !timedOut; i++) begin
            // most addresses fall in a 40-wide window that slides every 75 commands
            if (($unsigned($random(seed)) % 5) != 0) begin
                addr = (i / 75) * 50 + $unsigned($random(seed)) % 40;
            end else begin
                addr = $unsigned($random(seed)) % oramPkg::NumValidBlock;
            end
            op   = ($random(seed) & 1) ? oramPkg::FeWrite : oramPkg::FeRead;
            data = $random(seed);
            sendCmd(op, addr[oramPkg::ORAMU-1:0], data, i);
        end
        waited = 0;
        if (!timedOut) begin
            do begin
                @(negedge Clock);
                waited++;
            end while ((expQ.size() != 0 || !CmdInReady) && waited < 2000);
            if (expQ.size() != 0 || !CmdInReady) begin
                $display("timeout: outstanding reads did not return within 2000 cycles");
                timedOut = 1'b1;
            end
        end
        $display("errors: data %0d, protocol %0d, backend %0d",
                 dataErrors, protocolErrors, modelFaults);
        if (!timedOut && dataErrors + protocolErrors + modelFaults == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: logic/dataScheduler.sv
`timescale 1ns/1ns

module dataScheduler (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         LoadValid,
    input  logic [oramPkg::FEDWidth-1:0] LoadData,
    input  oramPkg::loadKindE            loadKind,
    input  logic                         loadKindValid,
    input  logic                         zeroReturn,
    output logic                         refillValid,
    output logic [oramPkg::FEDWidth-1:0] refillData,
    output logic                         ReturnValid,
    input  logic                         ReturnReady,
    output logic [oramPkg::FEDWidth-1:0] ReturnData,
    output logic                         returnBusy
);

    // kinds of loads still owed by the backend, in issue order
    oramPkg::loadKindE                kindQ [oramPkg::QueueDepth];
    logic [oramPkg::KindPtrWidth-1:0] kindWr;
    logic [oramPkg::KindPtrWidth-1:0] kindRd;
    logic [oramPkg::KindPtrWidth:0]   kindCount;

    // return skid buffer
    logic [oramPkg::FEDWidth-1:0] skid [2];
    logic                         skidWr;
    logic                         skidRd;
    logic [1:0]                   skidCount;

    logic headIsData;
    logic retPush;
    logic retPop;

    assign headIsData  = kindQ[kindRd] == oramPkg::LoadData;
    assign refillValid = LoadValid && !headIsData;
    assign refillData  = LoadData;

    assign retPush     = (LoadValid && headIsData) || zeroReturn;
    assign retPop      = ReturnValid && ReturnReady;
    assign ReturnValid = skidCount != '0;
    assign ReturnData  = skid[skidRd];
    assign returnBusy  = kindCount != '0 || skidCount != '0;

    // ==================================================================
    // pointers and counts
    // ==================================================================
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            kindWr    <= '0;
            kindRd    <= '0;
            kindCount <= '0;
            skidWr    <= 1'b0;
            skidRd    <= 1'b0;
            skidCount <= '0;
        end else begin
            if (loadKindValid) begin
                kindWr <= kindWr + 1'b1;
            end
            if (LoadValid) begin
                kindRd <= kindRd + 1'b1;
            end
            if (loadKindValid && !LoadValid) begin
                kindCount <= kindCount + 1'b1;
            end else if (!loadKindValid && LoadValid) begin
                kindCount <= kindCount - 1'b1;
            end
            if (retPush) begin
                skidWr <= !skidWr;
            end
            if (retPop) begin
                skidRd <= !skidRd;
            end
            if (retPush && !retPop) begin
                skidCount <= skidCount + 1'b1;
            end else if (!retPush && retPop) begin
                skidCount <= skidCount - 1'b1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (loadKindValid) begin
            kindQ[kindWr] <= loadKind;
        end
        if (retPush) begin
            // uninitialized blocks read back as zero
            skid[skidWr] <= zeroReturn ? '0 : LoadData;
        end
    end

endmodule

// File: logic/oramFrontend.sv
`timescale 1ns/1ns

module oramFrontend (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         CmdInValid,
    output logic                         CmdInReady,
    input  oramPkg::feCmdT               CmdIn,
    output logic                         ReturnValid,
    input  logic                         ReturnReady,
    output logic [oramPkg::FEDWidth-1:0] ReturnData,
    output logic                         CmdOutValid,
    input  logic                         CmdOutReady,
    output oramPkg::beCmdT               CmdOut,
    input  logic                         LoadValid,
    input  logic [oramPkg::FEDWidth-1:0] LoadData
);

    // ==================================================================
    // controller to PLB
    // ==================================================================
    oramPkg::plbReqT              plbReq;
    logic                         plbReqValid;
    oramPkg::plbRspT              plbRsp;
    logic                         plbRspValid;
    logic                         evictValid;
    logic [oramPkg::ORAMU-1:0]    evictAddr;
    logic [oramPkg::ORAML-1:0]    evictLeaf;
    logic [oramPkg::FEDWidth-1:0] evictData;
    logic                         evictTaken;

    // ==================================================================
    // controller to data scheduler
    // ==================================================================
    logic                         refillValid;
    logic [oramPkg::FEDWidth-1:0] refillData;
    oramPkg::loadKindE            loadKind;
    logic                         loadKindValid;
    logic                         zeroReturn;
    logic                         returnBusy;

    recursionCtrl i_ctrl (.*);

    posMapCache i_plb (.*);

    dataScheduler i_sched (.*);

endmodule

// File: logic/oramPkg.sv
package oramPkg;

    // ==================================================================
    // sizes
    // ==================================================================
    localparam int ORAMU         = 10;
    localparam int ORAML         = 8;
    localparam int FEDWidth      = 32;
    localparam int LeafInBlock   = 4;
    localparam int NumValidBlock = 256;
    localparam int RootEntries   = 16;
    localparam int PlbEntries    = 16;
    localparam int Recursion     = 3;
    localparam int QueueDepth    = 4;

    // derived widths
    localparam int SlotWidth    = $clog2(LeafInBlock);
    localparam int PlbIdxWidth  = $clog2(PlbEntries);
    localparam int RootIdxWidth = $clog2(RootEntries);
    localparam int DepthWidth   = $clog2(Recursion);
    localparam int KindPtrWidth = $clog2(QueueDepth);

    // level-1 blocks sit right after the data blocks, level 2 after level 1
    localparam logic [ORAMU-1:0] Level1Base = ORAMU'(NumValidBlock);
    localparam logic [ORAMU-1:0] Level2Base = Level1Base + ORAMU'(NumValidBlock / LeafInBlock);

    // ==================================================================
    // opcodes and states
    // ==================================================================
    typedef enum logic {FeRead, FeWrite} feOpE;
    typedef enum logic [1:0] {BeRead, BeWrite, BeReadRmv, BeAppend} beOpE;
    typedef enum logic [2:0] {CtrlIdle, CtrlPrepare, CtrlRefill, CtrlAccess, CtrlReturn} ctrlStateE;
    typedef enum logic {LoadData, LoadPosMap} loadKindE;
    typedef enum logic {PlbLookup, PlbRefill} plbOpE;

    // ==================================================================
    // bundles
    // ==================================================================
    typedef struct packed {
        feOpE                op;
        logic [ORAMU-1:0]    addr;
        logic [FEDWidth-1:0] data;
    } feCmdT;

    typedef struct packed {
        beOpE                op;
        logic [ORAMU-1:0]    addr;
        logic [ORAML-1:0]    oldLeaf;
        logic [ORAML-1:0]    newLeaf;
        logic [FEDWidth-1:0] data;
    } beCmdT;

    typedef struct packed {
        plbOpE               op;
        logic [ORAMU-1:0]    addr;
        logic [FEDWidth-1:0] data;
    } plbReqT;

    typedef struct packed {
        logic             hit;
        logic [ORAML-1:0] oldLeaf;
        logic [ORAML-1:0] newLeaf;
        logic             uninit;
    } plbRspT;

    // position-map block holding the leaf of addr
    function automatic logic [ORAMU-1:0] parentOf(input logic [ORAMU-1:0] addr);
        return Level1Base + (addr >> SlotWidth);
    endfunction

endpackage

// File: logic/posMapCache.sv
`timescale 1ns/1ns

module posMapCache (
    input  logic                         Clock,
    input  logic                         rstN,
    input  oramPkg::plbReqT              plbReq,
    input  logic                         plbReqValid,
    output oramPkg::plbRspT              plbRsp,
    output logic                         plbRspValid,
    output logic                         evictValid,
    output logic [oramPkg::ORAMU-1:0]    evictAddr,
    output logic [oramPkg::ORAML-1:0]    evictLeaf,
    output logic [oramPkg::FEDWidth-1:0] evictData,
    input  logic                         evictTaken
);

    // direct-mapped PLB entries
    logic                         entryValid  [oramPkg::PlbEntries];
    logic [oramPkg::ORAMU-1:0]    entryTag    [oramPkg::PlbEntries];
    logic [oramPkg::FEDWidth-1:0] entryLeaves [oramPkg::PlbEntries];
    logic [oramPkg::ORAML-1:0]    entryLeaf   [oramPkg::PlbEntries];

    // leaves of the level-2 blocks
    logic [oramPkg::ORAML-1:0]    rootLeaf    [oramPkg::RootEntries];

    logic [15:0]                      lfsr;
    logic [oramPkg::ORAML-1:0]        freshLeaf;
    logic [oramPkg::ORAML-1:0]        lastLeaf;
    logic [oramPkg::ORAML-1:0]        curLeaf;
    logic [oramPkg::ORAMU-1:0]        parentAddr;
    logic [oramPkg::ORAMU-1:0]        rootOff;
    logic [oramPkg::PlbIdxWidth-1:0]  lookIdx;
    logic [oramPkg::PlbIdxWidth-1:0]  pendIdx;
    logic [oramPkg::RootIdxWidth-1:0] rootIdx;
    logic [oramPkg::SlotWidth-1:0]    slot;
    logic                             isRoot;
    logic                             lookHit;
    logic                             lookupReq;
    logic                             install;

    // refill waiting on its victim
    logic                         pendValid;
    logic [oramPkg::ORAMU-1:0]    pendAddr;
    logic [oramPkg::FEDWidth-1:0] pendData;

    // ==================================================================
    // lookup
    // ==================================================================
    assign parentAddr = oramPkg::parentOf(plbReq.addr);
    assign rootOff    = plbReq.addr - oramPkg::Level2Base;
    assign rootIdx    = rootOff[oramPkg::RootIdxWidth-1:0];
    assign lookIdx    = parentAddr[oramPkg::PlbIdxWidth-1:0];
    assign slot       = plbReq.addr[oramPkg::SlotWidth-1:0];
    assign isRoot     = plbReq.addr >= oramPkg::Level2Base;
    assign lookHit    = isRoot || (entryValid[lookIdx] && entryTag[lookIdx] == parentAddr);
    assign lookupReq  = plbReqValid && plbReq.op == oramPkg::PlbLookup;

    assign curLeaf = isRoot ? rootLeaf[rootIdx] :
                     entryLeaves[lookIdx][slot*oramPkg::ORAML +: oramPkg::ORAML];

    // low byte of the lfsr, or the high byte when the low one is zero
    assign freshLeaf = (lfsr[oramPkg::ORAML-1:0] != '0) ? lfsr[oramPkg::ORAML-1:0] :
                       lfsr[15 -: oramPkg::ORAML];

    // ==================================================================
    // refill and evict
    // ==================================================================
    assign pendIdx    = pendAddr[oramPkg::PlbIdxWidth-1:0];
    assign evictValid = pendValid && entryValid[pendIdx];
    assign evictAddr  = entryTag[pendIdx];
    assign evictLeaf  = entryLeaf[pendIdx];
    assign evictData  = entryLeaves[pendIdx];
    assign install    = pendValid && (!entryValid[pendIdx] || evictTaken);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            lfsr        <= 16'hACE1;
            plbRspValid <= 1'b0;
            pendValid   <= 1'b0;
            for (int i = 0; i < oramPkg::PlbEntries; i++) begin
                entryValid[i] <= 1'b0;
            end
            for (int i = 0; i < oramPkg::RootEntries; i++) begin
                rootLeaf[i] <= '0;
            end
        end else begin
            lfsr        <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            plbRspValid <= lookupReq || install;
            if (lookupReq && lookHit && isRoot) begin
                rootLeaf[rootIdx] <= freshLeaf;
            end
            if (plbReqValid && plbReq.op == oramPkg::PlbRefill) begin
                pendValid <= 1'b1;
            end else if (install) begin
                pendValid <= 1'b0;
            end
            if (install) begin
                entryValid[pendIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (lookupReq) begin
            plbRsp.hit     <= lookHit;
            plbRsp.oldLeaf <= curLeaf;
            plbRsp.newLeaf <= freshLeaf;
            plbRsp.uninit  <= curLeaf == '0;
            if (lookHit) begin
                // remembered as the leaf of the block refilled next
                lastLeaf <= freshLeaf;
                if (!isRoot) begin
                    entryLeaves[lookIdx][slot*oramPkg::ORAML +: oramPkg::ORAML] <= freshLeaf;
                end
            end
        end
        if (plbReqValid && plbReq.op == oramPkg::PlbRefill) begin
            pendAddr <= plbReq.addr;
            pendData <= plbReq.data;
        end
        if (install) begin
            entryTag[pendIdx]    <= pendAddr;
            entryLeaves[pendIdx] <= pendData;
            entryLeaf[pendIdx]   <= lastLeaf;
        end
    end

endmodule

// File: logic/recursionCtrl.sv
`timescale 1ns/1ns

module recursionCtrl (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         CmdInValid,
    output logic                         CmdInReady,
    input  oramPkg::feCmdT               CmdIn,
    output logic                         CmdOutValid,
    input  logic                         CmdOutReady,
    output oramPkg::beCmdT               CmdOut,
    output oramPkg::plbReqT              plbReq,
    output logic                         plbReqValid,
    input  oramPkg::plbRspT              plbRsp,
    input  logic                         plbRspValid,
    input  logic                         evictValid,
    input  logic [oramPkg::ORAMU-1:0]    evictAddr,
    input  logic [oramPkg::ORAML-1:0]    evictLeaf,
    input  logic [oramPkg::FEDWidth-1:0] evictData,
    output logic                         evictTaken,
    input  logic                         refillValid,
    input  logic [oramPkg::FEDWidth-1:0] refillData,
    output oramPkg::loadKindE            loadKind,
    output logic                         loadKindValid,
    output logic                         zeroReturn,
    input  logic                         returnBusy
);

    oramPkg::ctrlStateE state;
    oramPkg::feCmdT     cmdReg;
    oramPkg::plbRspT    rspReg;

    // entry 0 is the data block, deeper entries its position-map parents
    logic [oramPkg::ORAMU-1:0]      addrQ [oramPkg::Recursion];
    logic [oramPkg::DepthWidth-1:0] depth;
    logic [oramPkg::ORAMU-1:0]      curAddr;

    logic lookupPending;
    logic refillSent;
    logic isPosMap;
    logic isRead;
    logic cmdAccept;
    logic outAccept;
    logic refillReq;
    logic refillDone;
    logic accessDone;

    assign curAddr    = addrQ[depth];
    assign isPosMap   = curAddr >= oramPkg::Level1Base;
    assign isRead     = cmdReg.op == oramPkg::FeRead;
    assign CmdInReady = state == oramPkg::CtrlIdle;
    assign cmdAccept  = CmdInValid && CmdInReady;
    assign outAccept  = CmdOutValid && CmdOutReady;
    assign accessDone = state == oramPkg::CtrlAccess && outAccept;

    // uninitialized position-map blocks refill with zeros right away
    assign refillReq  = state == oramPkg::CtrlRefill && !refillSent &&
                        (refillValid || rspReg.uninit);
    assign refillDone = state == oramPkg::CtrlRefill && refillSent && plbRspValid;

    // ==================================================================
    // PLB requests
    // ==================================================================
    assign plbReqValid = lookupPending || refillReq;
    assign plbReq.op   = lookupPending ? oramPkg::PlbLookup : oramPkg::PlbRefill;
    assign plbReq.addr = curAddr;
    assign plbReq.data = rspReg.uninit ? '0 : refillData;

    // ==================================================================
    // backend commands
    // ==================================================================
    always_comb begin
        CmdOut      = '0;
        CmdOutValid = 1'b0;
        if (state == oramPkg::CtrlRefill) begin
            // write back the PLB victim first
            CmdOutValid    = evictValid;
            CmdOut.op      = oramPkg::BeAppend;
            CmdOut.addr    = evictAddr;
            CmdOut.newLeaf = evictLeaf;
            CmdOut.data    = evictData;
        end else if (state == oramPkg::CtrlAccess) begin
            CmdOutValid    = !(isPosMap && rspReg.uninit);
            CmdOut.addr    = curAddr;
            CmdOut.oldLeaf = rspReg.oldLeaf;
            CmdOut.newLeaf = rspReg.newLeaf;
            if (isPosMap) begin
                CmdOut.op = oramPkg::BeReadRmv;
            end else if (rspReg.uninit) begin
                CmdOut.op = oramPkg::BeAppend;
            end else if (isRead) begin
                CmdOut.op = oramPkg::BeRead;
            end else begin
                CmdOut.op = oramPkg::BeWrite;
            end
            if (!isPosMap && !isRead) begin
                CmdOut.data = cmdReg.data;
            end
        end
    end

    assign evictTaken    = state == oramPkg::CtrlRefill && evictValid && CmdOutReady;
    assign loadKind      = isPosMap ? oramPkg::LoadPosMap : oramPkg::LoadData;
    assign loadKindValid = accessDone && (isPosMap || (isRead && !rspReg.uninit));
    assign zeroReturn    = accessDone && !isPosMap && isRead && rspReg.uninit;

    // ==================================================================
    // FSM
    // ==================================================================
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state         <= oramPkg::CtrlIdle;
            depth         <= '0;
            lookupPending <= 1'b0;
            refillSent    <= 1'b0;
        end else begin
            lookupPending <= 1'b0;
            refillSent    <= state == oramPkg::CtrlRefill && (refillSent || refillReq) &&
                             !refillDone;
            case (state)
                oramPkg::CtrlIdle: begin
                    if (cmdAccept) begin
                        depth         <= '0;
                        lookupPending <= 1'b1;
                        state         <= oramPkg::CtrlPrepare;
                    end
                end
                oramPkg::CtrlPrepare: begin
                    if (plbRspValid && plbRsp.hit) begin
                        state <= oramPkg::CtrlAccess;
                    end else if (plbRspValid) begin
                        // on a miss go one level up
                        depth         <= depth + 1'b1;
                        lookupPending <= 1'b1;
                    end
                end
                oramPkg::CtrlAccess: begin
                    if (isPosMap && (rspReg.uninit || outAccept)) begin
                        state <= oramPkg::CtrlRefill;
                    end else if (outAccept) begin
                        state <= isRead ? oramPkg::CtrlReturn : oramPkg::CtrlIdle;
                    end
                end
                oramPkg::CtrlRefill: begin
                    // installed block makes the child lookup hit
                    if (refillDone) begin
                        depth         <= depth - 1'b1;
                        lookupPending <= 1'b1;
                        state         <= oramPkg::CtrlPrepare;
                    end
                end
                oramPkg::CtrlReturn: begin
                    if (!returnBusy) begin
                        state <= oramPkg::CtrlIdle;
                    end
                end
                default: state <= oramPkg::CtrlIdle;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (cmdAccept) begin
            cmdReg   <= CmdIn;
            addrQ[0] <= CmdIn.addr;
        end
        if (state == oramPkg::CtrlPrepare && plbRspValid) begin
            rspReg <= plbRsp;
            if (!plbRsp.hit) begin
                addrQ[depth + 1'b1] <= oramPkg::parentOf(curAddr);
            end
        end
    end

endmodule

// File: verilog.f
logic/oramPkg.sv
logic/posMapCache.sv
logic/recursionCtrl.sv
logic/dataScheduler.sv
logic/oramFrontend.sv
dv/backendModel.sv
dv/oramFrontendTb.sv
